//--- tb.f
+incdir+common
common/mmio_pkg.sv
hw/mmio_ctrl.sv
hw/gpio/gpio_regs.sv
hw/irq_route.sv
hw/timer/counter_timer.sv
hw/mmio_top.sv
bench/tb_clkgen.sv
bench/mmio_asserts.sv
bench/mmio_tb.sv

//--- Makefile
TOP       ?= mmio_tb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/mmio_tb.sv
// table-driven testbench for the MMIO block with AXI4-Lite bus tasks and watchdog
`timescale 1ns/1ps
`include "mmio_settings.svh"

module mmio_tb;

  typedef enum {OP_WR, OP_WR_ERR, OP_RD, OP_RD_ERR, OP_POLL, OP_DRIVE, OP_PAD, OP_IRQ} op_e;

  // for writes the low four mask bits are the byte strobe
  typedef struct {
    string       name;
    op_e         op;
    logic [7:0]  addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] mask;
  } test_t;

  localparam logic [7:0] PAD_OUT = 8'd0;
  localparam logic [7:0] PAD_OEB = 8'd1;
  localparam logic [7:0] PAD_PU  = 8'd2;
  localparam logic [7:0] PAD_PD  = 8'd3;
  localparam int POLL_MAX = 64;

  logic                 clk;
  logic                 rst_n;
  mmio_pkg::axil_req_t  req;
  mmio_pkg::axil_rsp_t  rsp;
  logic [`GPIO_W-1:0]   gpio_in;
  logic                 xtal;
  logic                 pll;
  logic                 trap;
  mmio_pkg::gpio_pad_t  pad;
  mmio_pkg::irq_lines_t irq;

  test_t tests[$];
  int    seed;
  int    passed;
  int    failed;
  bit    table_ready;

  tb_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mmio_top i_mmio_top (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .axil_req_i (req),
    .axil_rsp_o (rsp),
    .gpio_in_i  (gpio_in),
    .xtal_i     (xtal),
    .pll_i      (pll),
    .trap_i     (trap),
    .gpio_pad_o (pad),
    .irq_o      (irq)
  );

  function automatic void add_test(string name, op_e op, logic [7:0] addr,
                                   logic [31:0] data, logic [31:0] exp, logic [31:0] mask);
    test_t t;
    t.name = name;
    t.op   = op;
    t.addr = addr;
    t.data = data;
    t.exp  = exp;
    t.mask = mask;
    tests.push_back(t);
  endfunction

  function automatic void reg_write(string name, logic [7:0] addr, logic [31:0] data);
    add_test(name, OP_WR, addr, data, 32'h0, 32'hf);
  endfunction

  function automatic void expect_read(string name, logic [7:0] addr, logic [31:0] exp);
    add_test(name, OP_RD, addr, 32'h0, exp, 32'hffff_ffff);
  endfunction

  // one destination code: the pin follows its source and the group is claimed
  function automatic void sf_steps(string tag, logic [7:0] addr, int code, int pin,
                                   int src_bit, logic [31:0] grp);
    logic [31:0] pin_m;
    pin_m = 32'd1 << pin;
    reg_write($sformatf("%s code %0d", tag, code), addr, code);
    add_test($sformatf("%s src high", tag), OP_DRIVE, 8'h0, 32'd1 << src_bit, 0, 0);
    add_test($sformatf("%s pin %0d high", tag, pin), OP_PAD, PAD_OUT, 0, pin_m, pin_m);
    add_test($sformatf("%s src low", tag), OP_DRIVE, 8'h0, 32'h0, 0, 0);
    add_test($sformatf("%s pin %0d low", tag, pin), OP_PAD, PAD_OUT, 0, 32'h0, pin_m);
    add_test($sformatf("%s group oeb", tag), OP_PAD, PAD_OEB, 0, 32'h0, grp);
    add_test($sformatf("%s group pu", tag), OP_PAD, PAD_PU, 0, grp, grp);
    add_test($sformatf("%s group pd", tag), OP_PAD, PAD_PD, 0, grp, grp);
  endfunction

  function automatic void build_table();
    logic [7:0]  offs [15];
    logic [15:0] r_oeb;
    logic [15:0] r_pu;
    logic [15:0] r_pd;
    logic [15:0] r_dat;
    logic [15:0] r_in;
    offs = '{`GPIO_DATA, `GPIO_OEB, `GPIO_PU, `GPIO_PD, `XTAL_DEST, `PLL_DEST, `TRAP_DEST,
             `IRQ7_SRC, `IRQ8_SRC, `TIM0_CFG, `TIM0_VAL, `TIM0_DAT, `TIM1_CFG, `TIM1_VAL,
             `TIM1_DAT};
    foreach (offs[i]) begin
      expect_read($sformatf("reset value at %02h", offs[i]), offs[i],
                  (offs[i] == `GPIO_OEB) ? 32'h0000_ffff : 32'h0);
    end
    r_oeb = 16'($random(seed));
    r_pu  = 16'($random(seed));
    r_pd  = 16'($random(seed));
    r_dat = 16'($random(seed));
    r_in  = 16'($random(seed));
    reg_write("oeb random", `GPIO_OEB, {16'h0, r_oeb});
    expect_read("oeb readback", `GPIO_OEB, {16'h0, r_oeb});
    reg_write("pu random", `GPIO_PU, {16'h0, r_pu});
    expect_read("pu readback", `GPIO_PU, {16'h0, r_pu});
    reg_write("pd random", `GPIO_PD, {16'h0, r_pd});
    expect_read("pd readback", `GPIO_PD, {16'h0, r_pd});
    add_test("pd byte 1 strobe", OP_WR, `GPIO_PD, 32'h5a5a, 0, 32'h2);
    expect_read("pd byte 1 only", `GPIO_PD, {16'h0, 8'h5a, r_pd[7:0]});
    add_test("pu byte 0 strobe", OP_WR, `GPIO_PU, 32'ha5a5, 0, 32'h1);
    expect_read("pu byte 0 only", `GPIO_PU, {16'h0, r_pu[15:8], 8'ha5});
    reg_write("oeb all outputs", `GPIO_OEB, 32'h0);
    add_test("pad oeb low", OP_PAD, PAD_OEB, 0, 32'h0, 32'hffff);
    reg_write("data random", `GPIO_DATA, {16'h0, r_dat});
    add_test("gpio_in random", OP_DRIVE, 8'h0, {16'h0, r_in}, 0, 0);
    add_test("pad out data", OP_PAD, PAD_OUT, 0, {16'h0, r_dat}, 32'hffff);
    expect_read("data read merge", `GPIO_DATA, {r_dat, r_in});

    // plain pads as inputs so only the claimed groups show oeb 0
    reg_write("oeb all inputs", `GPIO_OEB, 32'hffff);
    reg_write("pu clear", `GPIO_PU, 32'h0);
    reg_write("pd clear", `GPIO_PD, 32'h0);
    reg_write("data clear", `GPIO_DATA, 32'h0);
    add_test("inputs low", OP_DRIVE, 8'h0, 32'h0, 0, 0);
    for (int c = 1; c <= 3; c++) begin
      sf_steps($sformatf("xtal %0d", c), `XTAL_DEST, c, 4 + c, 16, 32'h00e0);
    end
    reg_write("xtal off", `XTAL_DEST, 32'h0);
    for (int c = 1; c <= 2; c++) begin
      sf_steps($sformatf("pll %0d", c), `PLL_DEST, c, 7 + c, 17, 32'h0700);
    end
    reg_write("pll off", `PLL_DEST, 32'h0);
    for (int c = 1; c <= 3; c++) begin
      sf_steps($sformatf("trap %0d", c), `TRAP_DEST, c, 10 + c, 18, 32'h3800);
    end
    reg_write("trap off", `TRAP_DEST, 32'h0);
    add_test("groups released", OP_PAD, PAD_OEB, 0, 32'hffff, 32'hffff);

    // irq_o packs irq7, irq8, tim0, tim1 from the msb down
    for (int c = 1; c <= 3; c++) begin
      reg_write($sformatf("irq7 src %0d", c), `IRQ7_SRC, c);
      reg_write($sformatf("irq8 src %0d", c), `IRQ8_SRC, c);
      add_test($sformatf("irq7 input %0d", c - 1), OP_DRIVE, 8'h0, 32'd1 << (c - 1), 0, 0);
      add_test($sformatf("irq7 follows %0d", c), OP_IRQ, 8'h0, 0, 32'b1000, 32'b1100);
      add_test($sformatf("irq8 input %0d", c + 2), OP_DRIVE, 8'h0, 32'd1 << (c + 2), 0, 0);
      add_test($sformatf("irq8 follows %0d", c), OP_IRQ, 8'h0, 0, 32'b0100, 32'b1100);
    end
    reg_write("irq7 src off", `IRQ7_SRC, 32'h0);
    reg_write("irq8 src off", `IRQ8_SRC, 32'h0);
    add_test("all sources high", OP_DRIVE, 8'h0, 32'h3f, 0, 0);
    add_test("irq parked low", OP_IRQ, 8'h0, 0, 32'b0000, 32'b1100);

    reg_write("tim0 val", `TIM0_VAL, 32'd20);
    reg_write("tim0 dat", `TIM0_DAT, 32'd20);
    reg_write("tim0 one-shot", `TIM0_CFG, 32'b0101);
    add_test("tim0 counts to 0", OP_POLL, `TIM0_DAT, 0, 32'h0, 32'hffff_ffff);
    add_test("tim0 done, en clear", OP_POLL, `TIM0_CFG, 0, 32'b1100, 32'hf);
    add_test("tim0 irq high", OP_IRQ, 8'h0, 0, 32'b0010, 32'b0010);
    reg_write("tim0 cfg rewrite", `TIM0_CFG, 32'b0100);
    add_test("tim0 irq cleared", OP_IRQ, 8'h0, 0, 32'b0000, 32'b0010);
    expect_read("tim0 done cleared", `TIM0_CFG, 32'b0100);
    // large reload keeps the wrapped count above 0x1000 for a while
    reg_write("tim1 val", `TIM1_VAL, 32'h1080);
    reg_write("tim1 dat", `TIM1_DAT, 32'd20);
    reg_write("tim1 continuous", `TIM1_CFG, 32'b0111);
    add_test("tim1 done", OP_POLL, `TIM1_CFG, 0, 32'b1000, 32'b1000);
    add_test("tim1 irq high", OP_IRQ, 8'h0, 0, 32'b0001, 32'b0001);
    add_test("tim1 still enabled", OP_RD, `TIM1_CFG, 0, 32'b0001, 32'b0001);
    add_test("tim1 reloaded", OP_RD, `TIM1_DAT, 0, 32'h1000, 32'hffff_ff00);
    reg_write("tim1 stop", `TIM1_CFG, 32'h0);

    add_test("inputs cleared", OP_DRIVE, 8'h0, 32'h0, 0, 0);
    add_test("unmapped read", OP_RD_ERR, 8'h80, 0, 32'h0, 32'hffff_ffff);
    add_test("unmapped write", OP_WR_ERR, 8'h80, 32'hffff_ffff, 0, 32'hf);
    expect_read("oeb unchanged", `GPIO_OEB, 32'hffff);
    expect_read("pu unchanged", `GPIO_PU, 32'h0);
    expect_read("pd unchanged", `GPIO_PD, 32'h0);
    expect_read("data unchanged", `GPIO_DATA, 32'h0);
    expect_read("tim1 val unchanged", `TIM1_VAL, 32'h1080);
  endfunction

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp,
                           output bit wready_seen);
    @(posedge clk);
    #1;
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = strb;
    req.bready  = 1'b1;
    @(negedge clk);
    while (!rsp.awready) begin
      @(negedge clk);
    end
    // both channels are taken in the same cycle
    wready_seen = rsp.wready;
    @(posedge clk);
    #1;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    @(negedge clk);
    while (!rsp.bvalid) begin
      @(negedge clk);
    end
    resp = rsp.bresp;
    @(posedge clk);
    #1;
    req.bready = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clk);
    #1;
    req.arvalid = 1'b1;
    req.araddr  = addr;
    req.rready  = 1'b1;
    @(negedge clk);
    while (!rsp.arready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req.arvalid = 1'b0;
    @(negedge clk);
    while (!rsp.rvalid) begin
      @(negedge clk);
    end
    data = rsp.rdata;
    resp = rsp.rresp;
    @(posedge clk);
    #1;
    req.rready = 1'b0;
  endtask

  function automatic logic [15:0] pad_field(input logic [7:0] sel);
    case (sel)
      PAD_OUT: return pad.out;
      PAD_OEB: return pad.oeb;
      PAD_PU:  return pad.pu;
      default: return pad.pd;
    endcase
  endfunction

  task automatic run_test(input test_t t);
    logic [31:0] got;
    logic [1:0]  resp;
    logic [1:0]  want_resp;
    int          reads;
    bit          ok;
    bit          wready_seen;
    ok = 1'b1;
    got = '0;
    resp = `AXI_RESP_OKAY;
    wready_seen = 1'b0;
    want_resp = (t.op == OP_WR_ERR || t.op == OP_RD_ERR) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
    case (t.op)
      OP_WR, OP_WR_ERR: begin
        bus_write(t.addr, t.data, t.mask[3:0], resp, wready_seen);
        if (!wready_seen) begin
          $display("Error %s: wready did not rise together with awready", t.name);
          ok = 1'b0;
        end else if (resp !== want_resp) begin
          $display("Mismatch %s: expected resp %0d, actual resp %0d", t.name, want_resp, resp);
          ok = 1'b0;
        end
      end
      OP_RD, OP_RD_ERR: begin
        bus_read(t.addr, got, resp);
        if (resp !== want_resp) begin
          $display("Mismatch %s: expected resp %0d, actual resp %0d", t.name, want_resp, resp);
          ok = 1'b0;
        end else if ((got & t.mask) !== t.exp) begin
          $display("Mismatch %s: expected %h, actual %h", t.name, t.exp, got & t.mask);
          ok = 1'b0;
        end
      end
      OP_POLL: begin
        bus_read(t.addr, got, resp);
        reads = 1;
        while (((got & t.mask) !== t.exp) && reads < POLL_MAX) begin
          bus_read(t.addr, got, resp);
          reads++;
        end
        if ((got & t.mask) !== t.exp) begin
          $display("Error %s: value %h never appeared in %0d reads", t.name, t.exp, reads);
          ok = 1'b0;
        end
      end
      OP_DRIVE: begin
        @(posedge clk);
        #1;
        gpio_in = t.data[15:0];
        xtal    = t.data[16];
        pll     = t.data[17];
        trap    = t.data[18];
      end
      OP_PAD: begin
        @(negedge clk);
        got = {16'h0000, pad_field(t.addr)};
        if ((got & t.mask) !== t.exp) begin
          $display("Mismatch %s: expected %h, actual %h", t.name, t.exp, got & t.mask);
          ok = 1'b0;
        end
      end
      default: begin
        @(negedge clk);
        got = {28'd0, irq};
        if ((got & t.mask) !== t.exp) begin
          $display("Mismatch %s: expected %h, actual %h", t.name, t.exp, got & t.mask);
          ok = 1'b0;
        end
      end
    endcase
    if (ok) begin
      passed++;
      $display("ok    %s", t.name);
    end else begin
      failed++;
    end
  endtask

  initial begin
    req         = '0;
    gpio_in     = '0;
    xtal        = 1'b0;
    pll         = 1'b0;
    trap        = 1'b0;
    passed      = 0;
    failed      = 0;
    seed        = 32'h88fc6357;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    wait (rst_n);
    foreach (tests[i]) begin
      run_test(tests[i]);
    end
    $display("%0d tests run, %0d passed, %0d failed", tests.size(), passed, failed);
    if (failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // generous budget per table entry
  initial begin
    wait (table_ready);
    repeat (tests.size() * 200) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", tests.size() * 200);
    $display("Test failed");
    $finish;
  end

endmodule

//--- bench/mmio_asserts.sv
// concurrent assertions on the AXI4-Lite handshake of the bus controller, with its bind
`timescale 1ns/1ps
`include "mmio_settings.svh"

module mmio_asserts (
  input logic                clk_i,
  input logic                rst_n_i,
  input mmio_pkg::axil_req_t axil_req_i,
  input mmio_pkg::axil_rsp_t axil_rsp_i
);

  logic aw_mapped;

  // offsets of the register map
  assign aw_mapped = axil_req_i.awaddr inside {`GPIO_DATA, `GPIO_OEB, `GPIO_PU, `GPIO_PD,
                                               `XTAL_DEST, `PLL_DEST, `TRAP_DEST,
                                               `IRQ7_SRC, `IRQ8_SRC,
                                               `TIM0_CFG, `TIM0_VAL, `TIM0_DAT,
                                               `TIM1_CFG, `TIM1_VAL, `TIM1_DAT};

  // responses hold until the master takes them
  bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid)
    else $error("rvalid dropped before rready");

  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (axil_rsp_i.awready || axil_rsp_i.wready) |-> (axil_req_i.awvalid && axil_req_i.wvalid))
    else $error("awready or wready without both valid signals");

  // mapped offsets always answer OKAY
  bresp_okay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    axil_rsp_i.awready && aw_mapped |=> axil_rsp_i.bresp == `AXI_RESP_OKAY)
    else $error("bresp not OKAY for a mapped offset");

endmodule

bind mmio_ctrl mmio_asserts u_asserts (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .axil_req_i (axil_req_i),
  .axil_rsp_i (axil_rsp_o)
);

//--- bench/tb_clkgen.sv
// testbench clock and reset generator
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held low for the first four rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

//--- hw/mmio_top.sv
// top level of the MMIO block, bus controller with GPIO, interrupt and timer blocks
`timescale 1ns/1ps
`include "mmio_settings.svh"

module mmio_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  mmio_pkg::axil_req_t  axil_req_i,
  output mmio_pkg::axil_rsp_t  axil_rsp_o,
  input  logic [`GPIO_W-1:0]   gpio_in_i,
  input  logic                 xtal_i,
  input  logic                 pll_i,
  input  logic                 trap_i,
  output mmio_pkg::gpio_pad_t  gpio_pad_o,
  output mmio_pkg::irq_lines_t irq_o
);

  mmio_pkg::reg_acc_t       acc;
  logic [`MMIO_DATA_W-1:0]  gpio_rdata;
  logic [`MMIO_DATA_W-1:0]  irq_rdata;
  logic [`MMIO_DATA_W-1:0]  tim0_rdata;
  logic [`MMIO_DATA_W-1:0]  tim1_rdata;
  logic                     irq7;
  logic                     irq8;
  logic                     tim0_irq;
  logic                     tim1_irq;

  mmio_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .axil_req_i   (axil_req_i),
    .axil_rsp_o   (axil_rsp_o),
    .acc_o        (acc),
    .gpio_rdata_i (gpio_rdata),
    .irq_rdata_i  (irq_rdata),
    .tim0_rdata_i (tim0_rdata),
    .tim1_rdata_i (tim1_rdata)
  );

  gpio_regs u_gpio (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .acc_i      (acc),
    .gpio_in_i  (gpio_in_i),
    .xtal_i     (xtal_i),
    .pll_i      (pll_i),
    .trap_i     (trap_i),
    .rdata_o    (gpio_rdata),
    .gpio_pad_o (gpio_pad_o)
  );

  irq_route u_irq (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .acc_i     (acc),
    .gpio_in_i (gpio_in_i),
    .rdata_o   (irq_rdata),
    .irq7_o    (irq7),
    .irq8_o    (irq8)
  );

  counter_timer #(
    .CFG_ID (mmio_pkg::REG_TIM0_CFG),
    .VAL_ID (mmio_pkg::REG_TIM0_VAL),
    .DAT_ID (mmio_pkg::REG_TIM0_DAT)
  ) u_tim0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .acc_i   (acc),
    .rdata_o (tim0_rdata),
    .irq_o   (tim0_irq)
  );

  counter_timer #(
    .CFG_ID (mmio_pkg::REG_TIM1_CFG),
    .VAL_ID (mmio_pkg::REG_TIM1_VAL),
    .DAT_ID (mmio_pkg::REG_TIM1_DAT)
  ) u_tim1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .acc_i   (acc),
    .rdata_o (tim1_rdata),
    .irq_o   (tim1_irq)
  );

  assign irq_o = '{irq7: irq7, irq8: irq8, tim0: tim0_irq, tim1: tim1_irq};

endmodule

//--- hw/timer/counter_timer.sv
// down-counting timer with reload value, one-shot or continuous mode and done interrupt
`timescale 1ns/1ps
`include "mmio_settings.svh"

module counter_timer #(
  parameter mmio_pkg::reg_id_e CFG_ID = mmio_pkg::REG_TIM0_CFG,
  parameter mmio_pkg::reg_id_e VAL_ID = mmio_pkg::REG_TIM0_VAL,
  parameter mmio_pkg::reg_id_e DAT_ID = mmio_pkg::REG_TIM0_DAT
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  mmio_pkg::reg_acc_t       acc_i,
  output logic [`MMIO_DATA_W-1:0]  rdata_o,
  output logic                     irq_o
);

  logic                     en_q;
  logic                     cont_q;
  logic                     ien_q;
  logic                     done_q;
  logic [`MMIO_DATA_W-1:0]  val_q;
  logic [`MMIO_DATA_W-1:0]  dat_q;
  logic                     cfg_wr;
  logic                     val_wr;
  logic                     dat_wr;

  // cfg only has bits in the low byte
  assign cfg_wr = acc_i.wr && (acc_i.id == CFG_ID) && acc_i.wstrb[0];
  assign val_wr = acc_i.wr && (acc_i.id == VAL_ID);
  assign dat_wr = acc_i.wr && (acc_i.id == DAT_ID);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q   <= 1'b0;
      cont_q <= 1'b0;
      ien_q  <= 1'b0;
      done_q <= 1'b0;
      val_q  <= '0;
      dat_q  <= '0;
    end else begin
      if (en_q) begin
        if (dat_q == '0) begin
          done_q <= 1'b1;
          if (cont_q) begin
            dat_q <= val_q;
          end else begin
            en_q <= 1'b0;
          end
        end else begin
          dat_q <= dat_q - 1'b1;
        end
      end
      // bus writes take priority over the count
      if (cfg_wr) begin
        en_q   <= acc_i.wdata[0];
        cont_q <= acc_i.wdata[1];
        ien_q  <= acc_i.wdata[2];
        done_q <= 1'b0;
      end
      if (val_wr) begin
        val_q <= mmio_pkg::wr_merge(val_q, acc_i);
      end
      if (dat_wr) begin
        dat_q <= mmio_pkg::wr_merge(dat_q, acc_i);
      end
    end
  end

  assign irq_o = done_q & ien_q;

  always_comb begin
    case (acc_i.id)
      CFG_ID:  rdata_o = {28'd0, done_q, ien_q, cont_q, en_q};
      VAL_ID:  rdata_o = val_q;
      DAT_ID:  rdata_o = dat_q;
      default: rdata_o = '0;
    endcase
  end

endmodule

//--- hw/irq_route.sv
// external interrupt source registers and GPIO source multiplexers
`timescale 1ns/1ps
`include "mmio_settings.svh"

module irq_route (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  mmio_pkg::reg_acc_t       acc_i,
  input  logic [`GPIO_W-1:0]       gpio_in_i,
  output logic [`MMIO_DATA_W-1:0]  rdata_o,
  output logic                     irq7_o,
  output logic                     irq8_o
);

  logic [1:0] irq7_src_q;
  logic [1:0] irq8_src_q;

  // code 00 parks the line low, 01..11 pick one of three inputs
  function automatic logic pick(input logic [1:0] code, input logic [2:0] src);
    case (code)
      2'b01:   pick = src[0];
      2'b10:   pick = src[1];
      2'b11:   pick = src[2];
      default: pick = 1'b0;
    endcase
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq7_src_q <= 2'b00;
      irq8_src_q <= 2'b00;
    end else if (acc_i.wr) begin
      if (acc_i.id == mmio_pkg::REG_IRQ7_SRC) begin
        irq7_src_q <= 2'(mmio_pkg::wr_merge(32'(irq7_src_q), acc_i));
      end
      if (acc_i.id == mmio_pkg::REG_IRQ8_SRC) begin
        irq8_src_q <= 2'(mmio_pkg::wr_merge(32'(irq8_src_q), acc_i));
      end
    end
  end

  assign irq7_o = pick(irq7_src_q, gpio_in_i[2:0]);
  assign irq8_o = pick(irq8_src_q, gpio_in_i[5:3]);

  always_comb begin
    case (acc_i.id)
      mmio_pkg::REG_IRQ7_SRC: rdata_o = {30'd0, irq7_src_q};
      mmio_pkg::REG_IRQ8_SRC: rdata_o = {30'd0, irq8_src_q};
      default:                rdata_o = '0;
    endcase
  end

endmodule

//--- hw/gpio/gpio_regs.sv
// GPIO data/oeb/pull registers, special-function destinations and pad overrides
`timescale 1ns/1ps
`include "mmio_settings.svh"

module gpio_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  mmio_pkg::reg_acc_t       acc_i,
  input  logic [`GPIO_W-1:0]       gpio_in_i,
  input  logic                     xtal_i,
  input  logic                     pll_i,
  input  logic                     trap_i,
  output logic [`MMIO_DATA_W-1:0]  rdata_o,
  output mmio_pkg::gpio_pad_t      gpio_pad_o
);

  logic [`GPIO_W-1:0] data_q;
  logic [`GPIO_W-1:0] oeb_q;
  logic [`GPIO_W-1:0] pu_q;
  logic [`GPIO_W-1:0] pd_q;
  logic [1:0]         xtal_dest_q;
  logic [1:0]         pll_dest_q;
  logic [1:0]         trap_dest_q;
  logic [3:0]         xtal_pin;
  logic [3:0]         pll_pin;
  logic [3:0]         trap_pin;
  logic [`GPIO_W-1:0] grp_mask;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_q      <= '0;
      oeb_q       <= `GPIO_OEB_RST;
      pu_q        <= '0;
      pd_q        <= '0;
      xtal_dest_q <= 2'b00;
      pll_dest_q  <= 2'b00;
      trap_dest_q <= 2'b00;
    end else if (acc_i.wr) begin
      case (acc_i.id)
        mmio_pkg::REG_GPIO_DATA: data_q <= 16'(mmio_pkg::wr_merge(32'(data_q), acc_i));
        mmio_pkg::REG_GPIO_OEB:  oeb_q  <= 16'(mmio_pkg::wr_merge(32'(oeb_q), acc_i));
        mmio_pkg::REG_GPIO_PU:   pu_q   <= 16'(mmio_pkg::wr_merge(32'(pu_q), acc_i));
        mmio_pkg::REG_GPIO_PD:   pd_q   <= 16'(mmio_pkg::wr_merge(32'(pd_q), acc_i));
        mmio_pkg::REG_XTAL_DEST: xtal_dest_q <= 2'(mmio_pkg::wr_merge(32'(xtal_dest_q), acc_i));
        mmio_pkg::REG_PLL_DEST:  pll_dest_q  <= 2'(mmio_pkg::wr_merge(32'(pll_dest_q), acc_i));
        mmio_pkg::REG_TRAP_DEST: trap_dest_q <= 2'(mmio_pkg::wr_merge(32'(trap_dest_q), acc_i));
        default: ;
      endcase
    end
  end

  // xtal on 5..7, pll on 8..9, trap on 11..13
  assign xtal_pin = 4'd4 + {2'b00, xtal_dest_q};
  assign pll_pin  = 4'd7 + {2'b00, pll_dest_q};
  assign trap_pin = 4'd10 + {2'b00, trap_dest_q};

  // an active destination claims its whole three-pin group
  assign grp_mask = {2'b00, {3{|trap_dest_q}}, {3{|pll_dest_q}}, {3{|xtal_dest_q}}, 5'b00000};

  always_comb begin
    gpio_pad_o.out = data_q;
    if (xtal_dest_q != 2'b00) begin
      gpio_pad_o.out[xtal_pin] = xtal_i;
    end
    // pll code 11 only takes the group, it drives no pin
    if (pll_dest_q == 2'b01 || pll_dest_q == 2'b10) begin
      gpio_pad_o.out[pll_pin] = pll_i;
    end
    if (trap_dest_q != 2'b00) begin
      gpio_pad_o.out[trap_pin] = trap_i;
    end
    // pads stay tristated while reset is held
    gpio_pad_o.oeb = (oeb_q & ~grp_mask) | {`GPIO_W{~rst_n_i}};
    gpio_pad_o.pu  = pu_q | grp_mask;
    gpio_pad_o.pd  = pd_q | grp_mask;
  end

  always_comb begin
    case (acc_i.id)
      mmio_pkg::REG_GPIO_DATA: rdata_o = {gpio_pad_o.out, gpio_in_i};
      mmio_pkg::REG_GPIO_OEB:  rdata_o = {16'h0000, oeb_q};
      mmio_pkg::REG_GPIO_PU:   rdata_o = {16'h0000, pu_q};
      mmio_pkg::REG_GPIO_PD:   rdata_o = {16'h0000, pd_q};
      mmio_pkg::REG_XTAL_DEST: rdata_o = {30'd0, xtal_dest_q};
      mmio_pkg::REG_PLL_DEST:  rdata_o = {30'd0, pll_dest_q};
      mmio_pkg::REG_TRAP_DEST: rdata_o = {30'd0, trap_dest_q};
      default:                 rdata_o = '0;
    endcase
  end

endmodule

//--- hw/mmio_ctrl.sv
// AXI4-Lite slave FSM, offset decode to register ids and read-data merge
`timescale 1ns/1ps
`include "mmio_settings.svh"

module mmio_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  mmio_pkg::axil_req_t      axil_req_i,
  output mmio_pkg::axil_rsp_t      axil_rsp_o,
  output mmio_pkg::reg_acc_t       acc_o,
  input  logic [`MMIO_DATA_W-1:0]  gpio_rdata_i,
  input  logic [`MMIO_DATA_W-1:0]  irq_rdata_i,
  input  logic [`MMIO_DATA_W-1:0]  tim0_rdata_i,
  input  logic [`MMIO_DATA_W-1:0]  tim1_rdata_i
);

  mmio_pkg::ctrl_state_e    state_q, state_d;
  mmio_pkg::reg_id_e        id;
  logic                     wr_go;
  logic                     rd_go;
  logic [`MMIO_ADDR_W-1:0]  addr;
  logic [1:0]               resp;
  logic [1:0]               bresp_q;
  logic [1:0]               rresp_q;
  logic [`MMIO_DATA_W-1:0]  rdata_mux;
  logic [`MMIO_DATA_W-1:0]  rdata_q;

  function automatic mmio_pkg::reg_id_e decode(input logic [`MMIO_ADDR_W-1:0] a);
    case (a)
      `GPIO_DATA: decode = mmio_pkg::REG_GPIO_DATA;
      `GPIO_OEB:  decode = mmio_pkg::REG_GPIO_OEB;
      `GPIO_PU:   decode = mmio_pkg::REG_GPIO_PU;
      `GPIO_PD:   decode = mmio_pkg::REG_GPIO_PD;
      `XTAL_DEST: decode = mmio_pkg::REG_XTAL_DEST;
      `PLL_DEST:  decode = mmio_pkg::REG_PLL_DEST;
      `TRAP_DEST: decode = mmio_pkg::REG_TRAP_DEST;
      `IRQ7_SRC:  decode = mmio_pkg::REG_IRQ7_SRC;
      `IRQ8_SRC:  decode = mmio_pkg::REG_IRQ8_SRC;
      `TIM0_CFG:  decode = mmio_pkg::REG_TIM0_CFG;
      `TIM0_VAL:  decode = mmio_pkg::REG_TIM0_VAL;
      `TIM0_DAT:  decode = mmio_pkg::REG_TIM0_DAT;
      `TIM1_CFG:  decode = mmio_pkg::REG_TIM1_CFG;
      `TIM1_VAL:  decode = mmio_pkg::REG_TIM1_VAL;
      `TIM1_DAT:  decode = mmio_pkg::REG_TIM1_DAT;
      default:    decode = mmio_pkg::REG_NONE;
    endcase
  endfunction

  // a write needs both channels, and wins over a read in the same cycle
  assign wr_go = (state_q == mmio_pkg::IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
  assign rd_go = (state_q == mmio_pkg::IDLE) && axil_req_i.arvalid && !wr_go;

  assign addr = wr_go ? axil_req_i.awaddr : axil_req_i.araddr;
  assign id   = decode(addr);
  assign resp = (id == mmio_pkg::REG_NONE) ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;

  assign acc_o = '{
    id:    id,
    wr:    wr_go,
    wstrb: wr_go ? axil_req_i.wstrb : 4'b0000,
    wdata: axil_req_i.wdata
  };

  // blocks return zero for ids that are not theirs
  assign rdata_mux = gpio_rdata_i | irq_rdata_i | tim0_rdata_i | tim1_rdata_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      mmio_pkg::IDLE: begin
        if (wr_go) begin
          state_d = mmio_pkg::WRESP;
        end else if (rd_go) begin
          state_d = mmio_pkg::RDATA;
        end
      end
      mmio_pkg::WRESP: begin
        if (axil_req_i.bready) begin
          state_d = mmio_pkg::IDLE;
        end
      end
      mmio_pkg::RDATA: begin
        if (axil_req_i.rready) begin
          state_d = mmio_pkg::IDLE;
        end
      end
      default: state_d = mmio_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= mmio_pkg::IDLE;
      bresp_q <= `AXI_RESP_OKAY;
      rresp_q <= `AXI_RESP_OKAY;
    end else begin
      state_q <= state_d;
      if (wr_go) begin
        bresp_q <= resp;
      end
      if (rd_go) begin
        rresp_q <= resp;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_go) begin
      rdata_q <= rdata_mux;
    end
  end

  assign axil_rsp_o = '{
    awready: wr_go,
    wready:  wr_go,
    bvalid:  state_q == mmio_pkg::WRESP,
    bresp:   bresp_q,
    arready: rd_go,
    rvalid:  state_q == mmio_pkg::RDATA,
    rdata:   rdata_q,
    rresp:   rresp_q
  };

endmodule

//--- common/mmio_pkg.sv
// register identifiers, FSM states, bus and pad structs, byte-strobe merge helper
`include "mmio_settings.svh"

package mmio_pkg;

  typedef enum logic [4:0] {
    REG_NONE,
    REG_GPIO_DATA,
    REG_GPIO_OEB,
    REG_GPIO_PU,
    REG_GPIO_PD,
    REG_XTAL_DEST,
    REG_PLL_DEST,
    REG_TRAP_DEST,
    REG_IRQ7_SRC,
    REG_IRQ8_SRC,
    REG_TIM0_CFG,
    REG_TIM0_VAL,
    REG_TIM0_DAT,
    REG_TIM1_CFG,
    REG_TIM1_VAL,
    REG_TIM1_DAT
  } reg_id_e;

  typedef enum logic [1:0] {
    IDLE,
    WRESP,
    RDATA
  } ctrl_state_e;

  // wstrb is only nonzero in the write commit cycle
  typedef struct packed {
    reg_id_e                  id;
    logic                     wr;
    logic [3:0]               wstrb;
    logic [`MMIO_DATA_W-1:0]  wdata;
  } reg_acc_t;

  typedef struct packed {
    logic [`GPIO_W-1:0] out;
    logic [`GPIO_W-1:0] oeb;
    logic [`GPIO_W-1:0] pu;
    logic [`GPIO_W-1:0] pd;
  } gpio_pad_t;

  typedef struct packed {
    logic irq7;
    logic irq8;
    logic tim0;
    logic tim1;
  } irq_lines_t;

  typedef struct packed {
    logic                     awvalid;
    logic [`MMIO_ADDR_W-1:0]  awaddr;
    logic                     wvalid;
    logic [`MMIO_DATA_W-1:0]  wdata;
    logic [3:0]               wstrb;
    logic                     bready;
    logic                     arvalid;
    logic [`MMIO_ADDR_W-1:0]  araddr;
    logic                     rready;
  } axil_req_t;

  typedef struct packed {
    logic                     awready;
    logic                     wready;
    logic                     bvalid;
    logic [1:0]               bresp;
    logic                     arready;
    logic                     rvalid;
    logic [`MMIO_DATA_W-1:0]  rdata;
    logic [1:0]               rresp;
  } axil_rsp_t;

  // old value with the strobed bytes of wdata laid over it
  function automatic logic [`MMIO_DATA_W-1:0] wr_merge(input logic [`MMIO_DATA_W-1:0] old,
                                                       input reg_acc_t acc);
    logic [`MMIO_DATA_W-1:0] mask;
    for (int i = 0; i < `MMIO_DATA_W / 8; i++) begin
      mask[i*8 +: 8] = {8{acc.wstrb[i]}};
    end
    return (old & ~mask) | (acc.wdata & mask);
  endfunction

endpackage

//--- common/mmio_settings.svh
// register map widths, register offsets, reset values and bus response codes
`ifndef MMIO_SETTINGS_SVH
`define MMIO_SETTINGS_SVH

`define MMIO_ADDR_W 8
`define MMIO_DATA_W 32
`define GPIO_W 16

// register offsets within the block
`define GPIO_DATA 8'h00
`define GPIO_OEB 8'h04
`define GPIO_PU 8'h08
`define GPIO_PD 8'h0c
`define XTAL_DEST 8'h34
`define PLL_DEST 8'h38
`define TRAP_DEST 8'h3c
`define IRQ7_SRC 8'h40
`define IRQ8_SRC 8'h44
`define TIM0_CFG 8'h5c
`define TIM0_VAL 8'h60
`define TIM0_DAT 8'h64
`define TIM1_CFG 8'h68
`define TIM1_VAL 8'h6c
`define TIM1_DAT 8'h70

// pads come up as inputs
`define GPIO_OEB_RST 16'hffff

`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10

`endif
